// File: list.f
verilog/memPkg.sv
verilog/memIfs.sv
verilog/memCtrl.sv
verilog/instFetch.sv
verilog/loadStore.sv
verilog/ramModel.sv
verilog/memSys.sv
verification/memSys_props.sv
verification/tb_memSys.sv

// File: run.sh
#!/bin/bash
# build and run the memSys testbench, a crashed run also counts as failed
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_memSys -f list.f -o simv \
    && { ./obj_dir/simv > sim.log 2>&1 || echo "TEST FAILED" >> sim.log; } \
    && cat sim.log \
    && ! grep -q "TEST FAILED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verification/tb_memSys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memSys;
    import memPkg::*;

    logic             clk;
    logic             rst;
    logic             ioFull;
    logic             fetchEn;
    logic             redirect;
    logic [addrW-1:0] redirectPc;
    logic             instValid;
    logic [addrW-1:0] instPc;
    logic [wordW-1:0] inst;
    logic             lsReq;
    logic             lsStore;
    accSize           lsSize;
    logic             lsUnsigned;
    logic [addrW-1:0] lsAddr;
    logic [wordW-1:0] lsWrData;
    logic             lsDone;
    logic [wordW-1:0] lsResult;

    logic [byteW-1:0] shadow [2**ramAddrW];
    logic [31:0]      lfsr = 32'hb27b;
    logic [addrW-1:0] expPc;
    logic             stallMode;
    int               fetchCount;
    int               lsCount;
    int               errors;
    int               timeouts;

    memSys u_memSys (
        .clk        (clk),
        .rst        (rst),
        .ioFull     (ioFull),
        .fetchEn    (fetchEn),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instValid  (instValid),
        .instPc     (instPc),
        .inst       (inst),
        .lsReq      (lsReq),
        .lsStore    (lsStore),
        .lsSize     (lsSize),
        .lsUnsigned (lsUnsigned),
        .lsAddr     (lsAddr),
        .lsWrData   (lsWrData),
        .lsDone     (lsDone),
        .lsResult   (lsResult)
    );

    always #50 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] nextBits(input int n);
        logic [31:0] val;
        logic        fb;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic accSize pickSize();
        logic [1:0] sel;
        sel = 2'(nextBits(2));
        case (sel)
            2'd0:    return sizeByte;
            2'd1:    return sizeHalf;
            default: return sizeWord;
        endcase
    endfunction

    function automatic logic [addrW-1:0] alignAddr(input logic [addrW-1:0] a, input accSize size);
        logic [addrW-1:0] r;
        r = a;
        if (size == sizeHalf) begin
            r[0] = 1'b0;
        end else if (size == sizeWord) begin
            r[1:0] = 2'b00;
        end
        return r;
    endfunction

    function automatic logic [wordW-1:0] fillPattern(input logic [addrW-1:0] a);
        return (a * 32'h9e37_79b9) ^ (a >> 7) ^ 32'h5bd1_e995;
    endfunction

    // little-endian assembly from the shadow, then sign or zero extension
    function automatic logic [wordW-1:0] refLoad(input logic [addrW-1:0] addr,
                                                 input accSize size, input logic uns);
        logic [wordW-1:0]    raw;
        logic [ramAddrW-1:0] idx;
        int                  k;
        raw = '0;
        for (k = 0; k < int'(accBytes(size)); k++) begin
            idx = addr[ramAddrW-1:0] + ramAddrW'(k);
            raw[8*k +: 8] = shadow[idx];
        end
        if (size == sizeByte && !uns && raw[7]) begin
            raw[31:8] = '1;
        end else if (size == sizeHalf && !uns && raw[15]) begin
            raw[31:16] = '1;
        end
        return raw;
    endfunction

    function automatic void writeShadow(input logic [addrW-1:0] addr, input accSize size,
                                        input logic [wordW-1:0] wdata);
        logic [ramAddrW-1:0] idx;
        int                  k;
        for (k = 0; k < int'(accBytes(size)); k++) begin
            idx = addr[ramAddrW-1:0] + ramAddrW'(k);
            shadow[idx] = wdata[8*k +: 8];
        end
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
        ioFull = 1'b0;
        if (stallMode) begin
            ioFull = (nextBits(1) != 0);
        end
    endtask

    task automatic issueAccess(input logic store, input accSize size, input logic uns,
                               input logic [addrW-1:0] addr, input logic [wordW-1:0] wdata);
        int target;
        int cycles;
        lsStore    = store;
        lsSize     = size;
        lsUnsigned = uns;
        lsAddr     = addr;
        lsWrData   = wdata;
        lsReq      = 1'b1;
        target     = lsCount + 1;
        cycles     = 0;
        tick();
        lsReq = 1'b0;
        while (lsCount < target && cycles < 200) begin
            tick();
            cycles++;
        end
        if (lsCount < target) begin
            timeouts++;
            $display("timeout: access at %h never completed, time %0t", addr, $time);
        end
    endtask

    task automatic randomAccess();
        logic             store;
        accSize           size;
        logic [addrW-1:0] a;
        store = (nextBits(1) != 0);
        size  = pickSize();
        a     = alignAddr(nextBits(32), size);
        issueAccess(store, size, (nextBits(1) != 0), a, nextBits(32));
    endtask

    task automatic waitFetches(input int n);
        int target;
        int cycles;
        target = fetchCount + n;
        cycles = 0;
        while (fetchCount < target && cycles < 40 * n + 20) begin
            tick();
            cycles++;
        end
        if (fetchCount < target) begin
            timeouts++;
            $display("timeout: instructions stopped arriving, time %0t", $time);
        end
    endtask

    task automatic pulseRedirect(input logic [addrW-1:0] pc);
        redirectPc = pc;
        redirect   = 1'b1;
        tick();
        redirect = 1'b0;
    endtask

    // inputs only move just after the rising edge so checks use the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (redirect) begin
                expPc = redirectPc;
            end
            if (instValid) begin
                assert (instPc == expPc) else begin
                    errors++;
                    $display("** Error at %0t: instPc %h, expected %h", $time, instPc, expPc);
                end
                assert (inst == refLoad(expPc, sizeWord, 1'b1)) else begin
                    errors++;
                    $display("** Error at %0t: inst %h at pc %h, expected %h", $time, inst,
                             expPc, refLoad(expPc, sizeWord, 1'b1));
                end
                expPc = expPc + 32'd4;
                fetchCount++;
            end
            if (lsDone) begin
                if (lsStore) begin
                    assert (lsResult == '0) else begin
                        errors++;
                        $display("** Error at %0t: store result %h, expected 0", $time, lsResult);
                    end
                    writeShadow(lsAddr, lsSize, lsWrData);
                end else begin
                    assert (lsResult == refLoad(lsAddr, lsSize, lsUnsigned)) else begin
                        errors++;
                        $display("** Error at %0t: load %h got %h, expected %h", $time, lsAddr,
                                 lsResult, refLoad(lsAddr, lsSize, lsUnsigned));
                    end
                end
                lsCount++;
            end
        end
    end

    initial begin
        logic [addrW-1:0] a;
        int               i;
        int               s;
        clk        = 1'b0;
        rst        = 1'b1;
        ioFull     = 1'b0;
        fetchEn    = 1'b0;
        redirect   = 1'b0;
        redirectPc = '0;
        lsReq      = 1'b0;
        lsStore    = 1'b0;
        lsSize     = sizeByte;
        lsUnsigned = 1'b0;
        lsAddr     = '0;
        lsWrData   = '0;
        expPc      = '0;
        stallMode  = 1'b0;
        fetchCount = 0;
        lsCount    = 0;
        errors     = 0;
        timeouts   = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (4) begin
            @(negedge clk);
            assert (!instValid && !lsDone && !u_memSys.ramWrite) else begin
                errors++;
                $display("** Error at %0t: strobe active with no request", $time);
            end
        end
        tick();

        // whole RAM gets known contents
        for (i = 0; i < 2**ramAddrW; i += 4) begin
            issueAccess(1'b1, sizeWord, 1'b0, addrW'(i), fillPattern(addrW'(i)));
        end

        // each store size in turn, read back at every size
        for (i = 0; i < 30; i++) begin
            a = nextBits(32);
            a[1:0] = 2'b00;
            issueAccess(1'b1, accSize'(i % 3), 1'b0, a, nextBits(32));
            for (s = 0; s < 3; s++) begin
                issueAccess(1'b0, accSize'(s), 1'b0, a, '0);
                issueAccess(1'b0, accSize'(s), 1'b1, a, '0);
            end
        end

        // first fetch comes from pc 0
        fetchEn = 1'b1;
        waitFetches(40);

        repeat (8) begin
            repeat (nextBits(3)) tick();
            a = nextBits(32);
            a[1:0] = 2'b00;
            pulseRedirect(a);
            waitFetches(3);
        end

        repeat (60) randomAccess();

        stallMode = 1'b1;
        repeat (60) randomAccess();
        waitFetches(5);
        stallMode = 1'b0;
        waitFetches(2);

        fetchEn = 1'b0;
        repeat (10) tick();
        $display("errors: %0d mismatches, %0d timeouts (%0d fetches, %0d loads/stores)",
                 errors, timeouts, fetchCount, lsCount);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/memSys_props.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrlProps (
    input logic          clk,
    input logic          rst,
    input logic          ioFull,
    input logic          ramWrite,
    input logic          fetchDone,
    input logic          dataDone,
    input memPkg::ownerT owner,
    input memPkg::stageT stage
);
    import memPkg::*;

    // unstalled cycles seen by the fetch holding the bus
    logic [2:0] fetchAge;

    always_ff @(posedge clk) begin
        if (rst || owner != ownerFetch) begin
            fetchAge <= '0;
        end else if (!ioFull) begin
            fetchAge <= fetchAge + 3'd1;
        end
    end

    oneDone: assert property (@(posedge clk) disable iff (rst) !(fetchDone && dataDone))
        else $error("done given to both ports in one cycle");

    noStallWrite: assert property (@(posedge clk) disable iff (rst) !(ioFull && ramWrite))
        else $error("RAM written while I/O buffer full");

    // accept cycle plus four owned cycles
    fetchDeadline: assert property (@(posedge clk) disable iff (rst)
        (owner == ownerFetch && !ioFull && fetchAge == 3'd3) |-> fetchDone)
        else $error("fetch not done within five unstalled cycles");

    idleStage: assert property (@(posedge clk) disable iff (rst)
        (owner == ownerIdle) |-> (stage == stageZero))
        else $error("stage not zero while idle");

endmodule

bind memCtrl memCtrlProps u_memCtrlProps (
    .clk       (clk),
    .rst       (rst),
    .ioFull    (ioFull),
    .ramWrite  (ramWrite),
    .fetchDone (fetch.done),
    .dataDone  (data.done),
    .owner     (owner),
    .stage     (stage)
);

`default_nettype wire

// File: verilog/memSys.sv
`timescale 1ns/1ps
`default_nettype none

module memSys (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ioFull,
    input  logic                     fetchEn,
    input  logic                     redirect,
    input  logic [memPkg::addrW-1:0] redirectPc,
    output logic                     instValid,
    output logic [memPkg::addrW-1:0] instPc,
    output logic [memPkg::wordW-1:0] inst,
    input  logic                     lsReq,
    input  logic                     lsStore,
    input  memPkg::accSize           lsSize,
    input  logic                     lsUnsigned,
    input  logic [memPkg::addrW-1:0] lsAddr,
    input  logic [memPkg::wordW-1:0] lsWrData,
    output logic                     lsDone,
    output logic [memPkg::wordW-1:0] lsResult
);
    import memPkg::*;

    logic [ramAddrW-1:0] ramAddr;
    logic                ramWrite;
    logic [byteW-1:0]    ramWrData;
    logic [byteW-1:0]    ramRdData;

    fetchIf fetchBus ();
    dataIf  dataBus ();

    instFetch u_instFetch (
        .clk        (clk),
        .rst        (rst),
        .fetchEn    (fetchEn),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instValid  (instValid),
        .instPc     (instPc),
        .inst       (inst),
        .fetch      (fetchBus)
    );

    loadStore u_loadStore (
        .clk        (clk),
        .rst        (rst),
        .lsReq      (lsReq),
        .lsStore    (lsStore),
        .lsSize     (lsSize),
        .lsUnsigned (lsUnsigned),
        .lsAddr     (lsAddr),
        .lsWrData   (lsWrData),
        .lsDone     (lsDone),
        .lsResult   (lsResult),
        .data       (dataBus)
    );

    memCtrl u_memCtrl (
        .clk       (clk),
        .rst       (rst),
        .ioFull    (ioFull),
        .ramRdData (ramRdData),
        .ramAddr   (ramAddr),
        .ramWrite  (ramWrite),
        .ramWrData (ramWrData),
        .fetch     (fetchBus),
        .data      (dataBus)
    );

    ramModel u_ramModel (
        .clk    (clk),
        .addr   (ramAddr),
        .write  (ramWrite),
        .wrData (ramWrData),
        .rdData (ramRdData)
    );

endmodule

`default_nettype wire

// File: verilog/ramModel.sv
`timescale 1ns/1ps
`default_nettype none

module ramModel (
    input  logic                        clk,
    input  logic [memPkg::ramAddrW-1:0] addr,
    input  logic                        write,
    input  logic [memPkg::byteW-1:0]    wrData,
    output logic [memPkg::byteW-1:0]    rdData
);
    import memPkg::*;

    logic [byteW-1:0] mem [2**ramAddrW];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= wrData;
        end
    end

    // read data registered, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rdData <= mem[addr];
    end

endmodule

`default_nettype wire

// File: verilog/loadStore.sv
`timescale 1ns/1ps
`default_nettype none

module loadStore (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     lsReq,
    input  logic                     lsStore,
    input  memPkg::accSize           lsSize,
    input  logic                     lsUnsigned,
    input  logic [memPkg::addrW-1:0] lsAddr,
    input  logic [memPkg::wordW-1:0] lsWrData,
    output logic                     lsDone,
    output logic [memPkg::wordW-1:0] lsResult,
    dataIf.requester                 data
);
    import memPkg::*;

    logic             busy;
    logic             cmdStore;
    accSize           cmdSize;
    logic             cmdUnsigned;
    logic [addrW-1:0] cmdAddr;
    logic [wordW-1:0] cmdWrData;
    logic             byteSign;
    logic             halfSign;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (data.done) begin
            busy <= 1'b0;
        end else if (lsReq) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (lsReq && !busy) begin
            cmdStore    <= lsStore;
            cmdSize     <= lsSize;
            cmdUnsigned <= lsUnsigned;
            cmdAddr     <= lsAddr;
            cmdWrData   <= lsWrData;
        end
    end

    assign data.req   = busy;
    assign data.store = cmdStore;
    assign data.size  = cmdSize;
    assign data.addr  = cmdAddr;
    assign data.wdata = cmdWrData;

    assign lsDone = data.done;

    assign byteSign = !cmdUnsigned && data.rdata[7];
    assign halfSign = !cmdUnsigned && data.rdata[15];

    // stores report zero
    always_comb begin
        lsResult = '0;
        if (!cmdStore) begin
            case (cmdSize)
                sizeByte: lsResult = {{(wordW-8){byteSign}}, data.rdata[7:0]};
                sizeHalf: lsResult = {{(wordW-16){halfSign}}, data.rdata[15:0]};
                default:  lsResult = data.rdata;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/instFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instFetch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetchEn,
    input  logic                     redirect,
    input  logic [memPkg::addrW-1:0] redirectPc,
    output logic                     instValid,
    output logic [memPkg::addrW-1:0] instPc,
    output logic [memPkg::wordW-1:0] inst,
    fetchIf.requester                fetch
);
    import memPkg::*;

    logic [addrW-1:0] pc;
    logic [addrW-1:0] heldAddr;
    logic             busy;
    logic             drop;

    // request stays up at the same address until done
    assign fetch.req  = busy || fetchEn;
    assign fetch.addr = busy ? heldAddr : pc;

    // a redirect kills the fetch that completes with it
    assign instValid = fetch.done && !drop && !redirect;
    assign instPc    = fetch.addr;
    assign inst      = fetch.inst;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= '0;
            busy <= 1'b0;
            drop <= 1'b0;
        end else begin
            if (fetch.done) begin
                busy <= 1'b0;
            end else if (fetch.req) begin
                busy <= 1'b1;
            end

            if (fetch.done) begin
                drop <= 1'b0;
            end else if (redirect && fetch.req) begin
                drop <= 1'b1;
            end

            if (redirect) begin
                pc <= redirectPc;
            end else if (instValid) begin
                pc <= fetch.addr + addrW'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.req && !busy) begin
            heldAddr <= pc;
        end
    end

endmodule

`default_nettype wire

// File: verilog/memCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ioFull,
    input  logic [memPkg::byteW-1:0]      ramRdData,
    output logic [memPkg::ramAddrW-1:0]   ramAddr,
    output logic                          ramWrite,
    output logic [memPkg::byteW-1:0]      ramWrData,
    fetchIf.ctrl                          fetch,
    dataIf.ctrl                           data
);
    import memPkg::*;

    ownerT            owner;
    ownerT            curOwner;
    stageT            stage;
    stageT            curStage;
    logic [addrW-1:0] base;
    logic [addrW-1:0] curBase;
    logic [wordW-1:0] word;
    logic [wordW-1:0] fullWord;
    logic [2:0]       stageNum;
    logic [2:0]       lastStage;
    logic [2:0]       addrOffset;
    logic [1:0]       rdSlot;
    logic             isLast;
    logic             doneNow;

    // idle cycle doubles as stage zero of a newly accepted request
    always_comb begin
        curOwner = owner;
        curStage = stage;
        curBase  = base;
        if (owner == ownerIdle) begin
            curStage = stageZero;
            if (data.req) begin
                curOwner = ownerData;
                curBase  = data.addr;
            end else if (fetch.req) begin
                curOwner = ownerFetch;
                curBase  = fetch.addr;
            end
        end
    end

    assign stageNum = curStage;

    // stores finish on their last write, loads one cycle after the last address
    always_comb begin
        if (curOwner == ownerData) begin
            if (data.store) begin
                lastStage = accBytes(data.size) - 3'd1;
            end else begin
                lastStage = accBytes(data.size);
            end
        end else begin
            lastStage = 3'd4;
        end
    end

    assign isLast  = (stageNum == lastStage);
    assign doneNow = !ioFull && isLast && (curOwner != ownerIdle);

    // stalled: re-present the previous address so read data survives the stall
    assign addrOffset = (ioFull && stageNum != 3'd0) ? stageNum - 3'd1 : stageNum;
    assign ramAddr    = ramAddrW'(curBase + addrW'(addrOffset));
    assign ramWrite   = !ioFull && (curOwner == ownerData) && data.store;
    assign ramWrData  = data.wdata[byteW*stageNum[1:0] +: byteW];

    // byte arriving now belongs to the previous stage's address
    assign rdSlot = 2'(stageNum - 3'd1);

    always_comb begin
        fullWord = word;
        if (stageNum != 3'd0) begin
            fullWord[byteW*rdSlot +: byteW] = ramRdData;
        end
    end

    assign fetch.done = doneNow && (curOwner == ownerFetch);
    assign fetch.inst = fullWord;
    assign data.done  = doneNow && (curOwner == ownerData);
    assign data.rdata = fullWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= ownerIdle;
            stage <= stageZero;
        end else if (!ioFull) begin
            if (doneNow) begin
                owner <= ownerIdle;
                stage <= stageZero;
            end else if (curOwner != ownerIdle) begin
                owner <= curOwner;
                stage <= stageT'(stageNum + 3'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ioFull) begin
            base <= curBase;
            if (owner == ownerIdle) begin
                word <= '0;
            end else begin
                word <= fullWord;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/memIfs.sv
`timescale 1ns/1ps
`default_nettype none

// instruction fetch port
interface fetchIf;
    import memPkg::*;

    logic             req;
    logic [addrW-1:0] addr;
    logic             done;
    logic [wordW-1:0] inst;

    modport requester (
        output req, addr,
        input  done, inst
    );

    modport ctrl (
        input  req, addr,
        output done, inst
    );
endinterface

// load/store port, rdata is raw little-endian bytes
interface dataIf;
    import memPkg::*;

    logic             req;
    logic             store;
    accSize           size;
    logic [addrW-1:0] addr;
    logic [wordW-1:0] wdata;
    logic             done;
    logic [wordW-1:0] rdata;

    modport requester (
        output req, store, size, addr, wdata,
        input  done, rdata
    );

    modport ctrl (
        input  req, store, size, addr, wdata,
        output done, rdata
    );
endinterface

`default_nettype wire

// File: verilog/memPkg.sv
`default_nettype none

package memPkg;

    localparam int addrW = 32;
    localparam int wordW = 32;
    localparam int byteW = 8;
    // RAM decodes only the low address bits
    localparam int ramAddrW = 12;

    typedef enum logic [1:0] {
        sizeByte,
        sizeHalf,
        sizeWord
    } accSize;

    // byte sequencer position
    typedef enum logic [2:0] {
        stageZero,
        stageOne,
        stageTwo,
        stageThree,
        stageFour
    } stageT;

    typedef enum logic [1:0] {
        ownerIdle,
        ownerFetch,
        ownerData
    } ownerT;

    function automatic logic [2:0] accBytes(accSize size);
        case (size)
            sizeByte: return 3'd1;
            sizeHalf: return 3'd2;
            default:  return 3'd4;
        endcase
    endfunction

endpackage

`default_nettype wire
